// File: source/telemetry_pkg.sv
package telemetry_pkg;

  // One telemetry record per state change
  localparam int record_bits = 16;
  localparam int hex_digits = record_bits / 4;

  // Field view, most significant field first
  typedef struct packed {
    logic [4:0] fsm_state;
    logic [4:0] fsm_snext;
    logic [2:0] ddl_state;
    logic       cfg_run;
    logic       cfg_req;
    logic       cfg_ref;
  } tele_fields_t;

  // The same word seen as fields on capture and as nibbles on dump
  typedef union packed {
    tele_fields_t                fields;
    logic [hex_digits-1:0][3:0]  nibbles;
  } tele_record_t;

  // Ends every record on the UART
  localparam logic [7:0] char_lf = 8'h0a;

  // Received character that starts a dump, "a"
  localparam logic [7:0] cmd_dump = 8'h61;

endpackage

// File: source/state_capture.sv
`timescale 1ns/1ps
module state_capture (
  input  logic                        clock,
  input  logic                        arst_n,
  input  logic [4:0]                  fsm_state_i,
  input  logic [4:0]                  fsm_snext_i,
  input  logic [2:0]                  ddl_state_i,
  input  logic                        cfg_run_i,
  input  logic                        cfg_req_i,
  input  logic                        cfg_ref_i,
  input  logic                        dumping_i,
  output logic                        wr_stb_o,
  output telemetry_pkg::tele_record_t wr_data_o
);
  import telemetry_pkg::*;

  tele_fields_t           sample_q;
  logic [record_bits-1:0] prev_q;
  logic                   stb_q;

  // Sample, then compare against the word of the cycle before
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      sample_q <= '0;
      prev_q   <= '0;
      stb_q    <= 1'b0;
    end else begin
      sample_q <= '{fsm_state: fsm_state_i, fsm_snext: fsm_snext_i, ddl_state: ddl_state_i,
                    cfg_run: cfg_run_i, cfg_req: cfg_req_i, cfg_ref: cfg_ref_i};
      // Tracks every cycle, also while dumping
      prev_q   <= sample_q;
      stb_q    <= (sample_q != prev_q) && !dumping_i;
    end
  end

  always_ff @(posedge clock) begin
    wr_data_o.fields <= sample_q;
  end

  // A change caught on the edge that starts a dump is dropped too
  assign wr_stb_o = stb_q & ~dumping_i;

endmodule

// File: source/telemetry_fifo.sv
`timescale 1ns/1ps
module telemetry_fifo #(
  parameter int FIFO_DEPTH = 64
) (
  input  logic                          clock,
  input  logic                          arst_n,
  input  logic                          wr_stb_i,
  input  telemetry_pkg::tele_record_t   wr_data_i,
  input  logic                          rd_stb_i,
  output telemetry_pkg::tele_record_t   rd_data_o,
  output logic                          empty_o,
  output logic [$clog2(FIFO_DEPTH):0]   level_o
);
  import telemetry_pkg::*;

  localparam int aw = $clog2(FIFO_DEPTH);
  localparam logic [aw-1:0] last_addr = aw'(FIFO_DEPTH - 1);

  tele_record_t  mem_q [FIFO_DEPTH];
  logic [aw-1:0] wr_ptr_q;
  logic [aw-1:0] rd_ptr_q;
  logic [aw:0]   level_next;
  logic          full;
  logic          do_wr;
  logic          do_rd;

  // Writes to a full buffer are lost
  assign full  = level_o == (aw + 1)'(FIFO_DEPTH);
  assign do_wr = wr_stb_i && !full;
  assign do_rd = rd_stb_i && !empty_o;

  assign level_next = level_o + (aw + 1)'(do_wr) - (aw + 1)'(do_rd);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_o  <= '0;
      empty_o  <= 1'b1;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= (wr_ptr_q == last_addr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= (rd_ptr_q == last_addr) ? '0 : rd_ptr_q + 1'b1;
      end
      level_o <= level_next;
      empty_o <= level_next == '0;
    end
  end

  // Read data lands one cycle after the pop and holds until the next
  always_ff @(posedge clock) begin
    if (do_wr) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
    if (do_rd) begin
      rd_data_o <= mem_q[rd_ptr_q];
    end
  end

endmodule

// File: source/hex_dump.sv
`timescale 1ns/1ps
module hex_dump (
  input  logic                        clock,
  input  logic                        arst_n,
  input  logic                        send_ni,
  input  logic                        rx_stb_i,
  input  logic [7:0]                  rx_byte_i,
  input  logic                        empty_i,
  input  telemetry_pkg::tele_record_t rd_data_i,
  input  logic                        tx_busy_i,
  output logic                        rd_stb_o,
  output logic                        dumping_o,
  output logic                        tx_stb_o,
  output logic [7:0]                  tx_byte_o
);
  import telemetry_pkg::*;

  localparam int dw = $clog2(hex_digits);

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_check = 2'd1;
  localparam logic [1:0] st_pop   = 2'd2;
  localparam logic [1:0] st_send  = 2'd3;

  logic [2:0]    sync_q;
  logic          press_q;
  logic          trigger;
  logic [1:0]    state_q;
  logic [dw-1:0] digit_q;
  logic          lf_q;
  logic          send_ok;
  logic [3:0]    nibble;
  logic [7:0]    ascii;

  // Button is active low and idles high
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      sync_q  <= 3'b111;
      press_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[1:0], send_ni};
      press_q <= sync_q[2] & ~sync_q[1];
    end
  end

  assign trigger = press_q || (rx_stb_i && rx_byte_i == cmd_dump);

  // Nibbles go out most significant first
  assign nibble  = rd_data_i.nibbles[digit_q];
  assign ascii   = (nibble < 4'd10) ? 8'h30 + {4'h0, nibble} : 8'h37 + {4'h0, nibble};
  // Hold off for one cycle after a strobe until busy shows up
  assign send_ok = (state_q == st_send) && !tx_busy_i && !tx_stb_o;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= st_idle;
      dumping_o <= 1'b0;
      rd_stb_o  <= 1'b0;
      tx_stb_o  <= 1'b0;
      digit_q   <= '0;
      lf_q      <= 1'b0;
    end else begin
      rd_stb_o <= 1'b0;
      tx_stb_o <= 1'b0;
      case (state_q)
        st_idle: begin
          if (trigger) begin
            dumping_o <= 1'b1;
            state_q   <= st_check;
          end
        end
        st_check: begin
          if (empty_i) begin
            dumping_o <= 1'b0;
            state_q   <= st_idle;
          end else begin
            rd_stb_o <= 1'b1;
            state_q  <= st_pop;
          end
        end
        st_pop: begin
          digit_q <= dw'(hex_digits - 1);
          lf_q    <= 1'b0;
          state_q <= st_send;
        end
        default: begin
          if (send_ok) begin
            tx_stb_o <= 1'b1;
            if (lf_q) begin
              state_q <= st_check;
            end else if (digit_q == '0) begin
              lf_q <= 1'b1;
            end else begin
              digit_q <= digit_q - 1'b1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (send_ok) begin
      tx_byte_o <= lf_q ? char_lf : ascii;
    end
  end

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ps
module uart_tx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       clock,
  input  logic       arst_n,
  input  logic       tx_stb_i,
  input  logic [7:0] tx_byte_i,
  output logic       tx_busy_o,
  output logic       txd_o
);

  localparam int cw = $clog2(CLKS_PER_BIT);
  localparam logic [cw-1:0] last_clk = cw'(CLKS_PER_BIT - 1);

  logic [cw-1:0] clk_cnt_q;
  logic [3:0]    bit_cnt_q;
  logic [8:0]    shift_q;
  logic          bit_end;

  assign bit_end = clk_cnt_q == last_clk;

  // Start bit goes out on the strobe edge, ten bit periods in all
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      tx_busy_o <= 1'b0;
      txd_o     <= 1'b1;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (!tx_busy_o) begin
      if (tx_stb_i) begin
        tx_busy_o <= 1'b1;
        txd_o     <= 1'b0;
        clk_cnt_q <= '0;
        bit_cnt_q <= '0;
      end
    end else if (bit_end) begin
      clk_cnt_q <= '0;
      if (bit_cnt_q == 4'd9) begin
        tx_busy_o <= 1'b0;
        txd_o     <= 1'b1;
      end else begin
        txd_o     <= shift_q[0];
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end else begin
      clk_cnt_q <= clk_cnt_q + 1'b1;
    end
  end

  // Data LSB first, stop bit shifted in from the top
  always_ff @(posedge clock) begin
    if (!tx_busy_o && tx_stb_i) begin
      shift_q <= {1'b1, tx_byte_i};
    end else if (tx_busy_o && bit_end) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

endmodule

// File: source/uart_rx.sv
`timescale 1ns/1ps
module uart_rx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       clock,
  input  logic       arst_n,
  input  logic       rxd_i,
  output logic       rx_stb_o,
  output logic [7:0] rx_byte_o
);

  localparam int cw = $clog2(CLKS_PER_BIT);
  localparam logic [cw-1:0] last_clk = cw'(CLKS_PER_BIT - 1);
  localparam logic [cw-1:0] mid_clk  = cw'(CLKS_PER_BIT / 2 - 1);

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_start = 2'd1;
  localparam logic [1:0] st_data  = 2'd2;
  localparam logic [1:0] st_stop  = 2'd3;

  logic [1:0]    sync_q;
  logic          rxd;
  logic [1:0]    state_q;
  logic [cw-1:0] clk_cnt_q;
  logic [2:0]    bit_cnt_q;
  logic [7:0]    shift_q;
  logic          bit_end;

  assign rxd     = sync_q[1];
  assign bit_end = clk_cnt_q == last_clk;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      sync_q    <= 2'b11;
      state_q   <= st_idle;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      rx_stb_o  <= 1'b0;
    end else begin
      sync_q   <= {sync_q[0], rxd_i};
      rx_stb_o <= 1'b0;
      case (state_q)
        st_idle: begin
          clk_cnt_q <= '0;
          bit_cnt_q <= '0;
          if (!rxd) begin
            state_q <= st_start;
          end
        end
        st_start: begin
          // Half a period in, a glitch has gone high again
          if (clk_cnt_q == mid_clk) begin
            clk_cnt_q <= '0;
            state_q   <= rxd ? st_idle : st_data;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        st_data: begin
          if (bit_end) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= st_stop;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: begin
          if (bit_end) begin
            clk_cnt_q <= '0;
            state_q   <= st_idle;
            // Frames with a low stop bit are dropped
            rx_stb_o  <= rxd;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == st_data && bit_end) begin
      shift_q <= {rxd, shift_q[7:1]};
    end
    if (state_q == st_stop && bit_end && rxd) begin
      rx_byte_o <= shift_q;
    end
  end

endmodule

// File: source/telemetry_top.sv
`timescale 1ns/1ps
module telemetry_top #(
  parameter int FIFO_DEPTH   = 64,
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                        clock,
  input  logic                        arst_n,
  input  logic [4:0]                  fsm_state_i,
  input  logic [4:0]                  fsm_snext_i,
  input  logic [2:0]                  ddl_state_i,
  input  logic                        cfg_run_i,
  input  logic                        cfg_req_i,
  input  logic                        cfg_ref_i,
  input  logic                        send_ni,
  input  logic                        uart_rx_i,
  output logic                        uart_tx_o,
  output logic [$clog2(FIFO_DEPTH):0] tele_level_o
);
  import telemetry_pkg::*;

  tele_record_t wr_data;
  tele_record_t rd_data;
  logic         wr_stb;
  logic         rd_stb;
  logic         empty;
  logic         dumping;
  logic         tx_stb;
  logic [7:0]   tx_byte;
  logic         tx_busy;
  logic         rx_stb;
  logic [7:0]   rx_byte;

  state_capture u_capture (
    .clock(clock), .arst_n(arst_n),
    .fsm_state_i(fsm_state_i), .fsm_snext_i(fsm_snext_i), .ddl_state_i(ddl_state_i),
    .cfg_run_i(cfg_run_i), .cfg_req_i(cfg_req_i), .cfg_ref_i(cfg_ref_i),
    .dumping_i(dumping), .wr_stb_o(wr_stb), .wr_data_o(wr_data)
  );

  telemetry_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clock(clock), .arst_n(arst_n),
    .wr_stb_i(wr_stb), .wr_data_i(wr_data), .rd_stb_i(rd_stb),
    .rd_data_o(rd_data), .empty_o(empty), .level_o(tele_level_o)
  );

  // Dump sequencer between the FIFO and the UART
  hex_dump u_dump (
    .clock(clock), .arst_n(arst_n),
    .send_ni(send_ni), .rx_stb_i(rx_stb), .rx_byte_i(rx_byte),
    .empty_i(empty), .rd_data_i(rd_data), .tx_busy_i(tx_busy),
    .rd_stb_o(rd_stb), .dumping_o(dumping), .tx_stb_o(tx_stb), .tx_byte_o(tx_byte)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
    .clock(clock), .arst_n(arst_n), .tx_stb_i(tx_stb), .tx_byte_i(tx_byte),
    .tx_busy_o(tx_busy), .txd_o(uart_tx_o)
  );

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
    .clock(clock), .arst_n(arst_n), .rxd_i(uart_rx_i),
    .rx_stb_o(rx_stb), .rx_byte_o(rx_byte)
  );

endmodule

// File: verification/telemetry_asserts.sv
`timescale 1ns/1ps
module telemetry_asserts #(
  parameter int FIFO_DEPTH = 64
) (
  input logic                        clock,
  input logic                        arst_n,
  input logic                        uart_tx_i,
  input logic                        tx_busy_i,
  input logic                        rd_stb_i,
  input logic                        empty_i,
  input logic                        dumping_i,
  input logic [$clog2(FIFO_DEPTH):0] level_i
);

  // Line rests at the stop level between frames
  idle_high: assert property (@(posedge clock) disable iff (!arst_n) !tx_busy_i |-> uart_tx_i)
    else $error("UART transmit line low while the transmitter is idle");

  no_empty_pop: assert property (@(posedge clock) disable iff (!arst_n) rd_stb_i |-> !empty_i)
    else $error("FIFO popped while empty");

  level_bound: assert property (@(posedge clock) disable iff (!arst_n) int'(level_i) <= FIFO_DEPTH)
    else $error("FIFO level above its depth");

  // Capture is frozen for the whole dump, so the level only falls
  no_dump_write: assert property (@(posedge clock) disable iff (!arst_n)
    dumping_i |=> level_i <= $past(level_i))
    else $error("Record written during a dump");

endmodule

bind telemetry_top telemetry_asserts #(.FIFO_DEPTH(FIFO_DEPTH)) u_asserts (
  .clock(clock), .arst_n(arst_n), .uart_tx_i(uart_tx_o), .tx_busy_i(tx_busy),
  .rd_stb_i(rd_stb), .empty_i(empty), .dumping_i(dumping),
  .level_i(tele_level_o)
);

// File: verification/telemetry_tb.sv
`timescale 1ns/1ps
module telemetry_tb;

  localparam int fifo_depth   = 8;
  localparam int clks_per_bit = 8;
  localparam int lw           = $clog2(fifo_depth) + 1;
  // Records over all tests, and the cycles spent outside the dumps
  localparam int max_records  = 17;
  localparam int stim_cycles  = 3000;
  localparam int cycle_limit  = (max_records * 5 * 10 * clks_per_bit + stim_cycles) * 2;

  logic          clock;
  logic          arst_n;
  logic [4:0]    fsm_state;
  logic [4:0]    fsm_snext;
  logic [2:0]    ddl_state;
  logic          cfg_run;
  logic          cfg_req;
  logic          cfg_ref;
  logic          send_n;
  logic          uart_rx;
  logic          uart_tx;
  logic [lw-1:0] level;

  integer        seed = 56227;
  int            cycles;
  int            errors = 0;
  int            checks = 0;
  int            test_errors = 0;
  int            chars_seen = 0;
  logic [15:0]   last_word;
  logic [15:0]   model_q[$];
  logic [7:0]    exp_q[$];
  logic [7:0]    rx_q[$];

  telemetry_top #(.FIFO_DEPTH(fifo_depth), .CLKS_PER_BIT(clks_per_bit)) dut0 (
    .clock(clock), .arst_n(arst_n),
    .fsm_state_i(fsm_state), .fsm_snext_i(fsm_snext), .ddl_state_i(ddl_state),
    .cfg_run_i(cfg_run), .cfg_req_i(cfg_req), .cfg_ref_i(cfg_ref),
    .send_ni(send_n), .uart_rx_i(uart_rx), .uart_tx_o(uart_tx), .tele_level_o(level)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #50 clock = ~clock;
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clock);
      cycles++;
      if (cycles >= cycle_limit) begin
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
      end
    end
  end

  // Expected characters of one record, the first one in the top byte
  function automatic logic [39:0] record_chars(input logic [15:0] rec);
    string       digits;
    logic [39:0] chars;
    digits = "0123456789ABCDEF";
    for (int i = 0; i < 4; i++) begin
      chars[39 - 8*i -: 8] = digits[rec[15 - 4*i -: 4]];
    end
    chars[7:0] = 8'h0a;
    return chars;
  endfunction

  function automatic logic [15:0] next_word(input logic [15:0] prev);
    logic [15:0] w;
    w = 16'($random(seed));
    if (w == prev) begin
      w = ~w;
    end
    return w;
  endfunction

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: FAILED with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic check_level(input int want);
    checks++;
    assert (int'(level) == want) else begin
      $display("MISMATCH at %0t: tele_level_o is %0d, expected %0d", $time, level, want);
      count_error();
    end
  endtask

  // Model keeps a change only outside a dump and while the FIFO has room
  task automatic apply_word(input logic [15:0] w, input int hold, input bit keep);
    @(posedge clock);
    fsm_state <= w[15:11];
    fsm_snext <= w[10:6];
    ddl_state <= w[5:3];
    cfg_run   <= w[2];
    cfg_req   <= w[1];
    cfg_ref   <= w[0];
    if (keep && w != last_word && model_q.size() < fifo_depth) begin
      model_q.push_back(w);
    end
    last_word = w;
    repeat (hold - 1) @(posedge clock);
  endtask

  task automatic expect_all(output int n);
    logic [39:0] chars;
    n = 0;
    while (model_q.size() > 0) begin
      chars = record_chars(model_q.pop_front());
      for (int i = 4; i >= 0; i--) begin
        exp_q.push_back(chars[8*i +: 8]);
        n++;
      end
    end
  endtask

  task automatic press_send();
    @(posedge clock);
    send_n <= 1'b0;
    repeat (4) @(posedge clock);
    send_n <= 1'b1;
  endtask

  // 8N1 frame into the DUT receiver
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clock);
      uart_rx <= frame[i];
      repeat (clks_per_bit - 1) @(posedge clock);
    end
  endtask

  task automatic wait_chars(input int target);
    while (chars_seen < target) begin
      @(negedge clock);
    end
  endtask

  // Serial receiver on the DUT transmit line, sampling mid bit
  initial begin
    logic [7:0] data;
    forever begin
      @(negedge uart_tx);
      repeat (clks_per_bit / 2) @(negedge clock);
      for (int i = 0; i < 8; i++) begin
        repeat (clks_per_bit) @(negedge clock);
        data[i] = uart_tx;
      end
      repeat (clks_per_bit) @(negedge clock);
      assert (uart_tx) else begin
        $display("Stop bit of byte 0x%02h is low at %0t", data, $time);
        count_error();
      end
      rx_q.push_back(data);
    end
  end

  // Compares each received byte with the next expected character
  initial begin
    logic [7:0] got;
    logic [7:0] want;
    forever begin
      @(negedge clock);
      while (rx_q.size() > 0) begin
        got = rx_q.pop_front();
        chars_seen++;
        assert (exp_q.size() > 0) else begin
          $display("Byte 0x%02h arrived at %0t while no output was expected", got, $time);
          count_error();
        end
        if (exp_q.size() > 0) begin
          want = exp_q.pop_front();
          checks++;
          assert (got == want) else begin
            $display("MISMATCH at %0t: UART byte 0x%02h, expected 0x%02h", $time, got, want);
            count_error();
          end
        end
      end
    end
  end

  initial begin
    int          n;
    int          target;
    logic [15:0] w;
    arst_n    = 1'b0;
    fsm_state = '0;
    fsm_snext = '0;
    ddl_state = '0;
    cfg_run   = 1'b0;
    cfg_req   = 1'b0;
    cfg_ref   = 1'b0;
    send_n    = 1'b1;
    uart_rx   = 1'b1;
    last_word = '0;
    target    = 0;
    repeat (10) @(posedge clock);
    arst_n <= 1'b1;

    repeat (3) @(negedge clock);
    checks++;
    assert (uart_tx === 1'b1) else begin
      $display("MISMATCH at %0t: uart_tx_o is %b after reset, expected 1", $time, uart_tx);
      count_error();
    end
    check_level(0);
    end_test("1 idle after reset");

    // Second and fifth words repeat the one before
    w = last_word;
    for (int i = 0; i < 5; i++) begin
      if (i != 1 && i != 4) begin
        w = next_word(w);
      end
      apply_word(w, 5, 1'b1);
    end
    repeat (4) @(posedge clock);
    @(negedge clock);
    check_level(model_q.size());
    end_test("2 capture count");

    expect_all(n);
    target += n;
    press_send();
    wait_chars(target);
    repeat (20 * clks_per_bit) @(posedge clock);
    @(negedge clock);
    check_level(0);
    end_test("3 button dump");

    for (int i = 0; i < 3; i++) begin
      w = next_word(w);
      apply_word(w, 4, 1'b1);
    end
    repeat (4) @(posedge clock);
    send_byte(8'h62);
    repeat (30 * clks_per_bit) @(posedge clock);
    checks++;
    assert (chars_seen == target) else begin
      $display("Character b started output on the transmit line");
      count_error();
    end
    expect_all(n);
    target += n;
    send_byte(8'h61);
    wait_chars(target);
    repeat (20 * clks_per_bit) @(posedge clock);
    @(negedge clock);
    check_level(0);
    end_test("4 command dump");

    for (int i = 0; i < 12; i++) begin
      w = next_word(w);
      apply_word(w, 3, 1'b1);
    end
    repeat (4) @(posedge clock);
    @(negedge clock);
    check_level(fifo_depth);
    expect_all(n);
    target += n;
    press_send();
    wait_chars(target);
    repeat (20 * clks_per_bit) @(posedge clock);
    @(negedge clock);
    check_level(0);
    end_test("5 overflow");

    for (int i = 0; i < 3; i++) begin
      w = next_word(w);
      apply_word(w, 4, 1'b1);
    end
    repeat (4) @(posedge clock);
    expect_all(n);
    target += n;
    press_send();
    // Changes land while the second byte is on the line
    wait_chars(target - n + 1);
    for (int i = 0; i < 3; i++) begin
      w = next_word(w);
      apply_word(w, 3, 1'b0);
    end
    wait_chars(target);
    repeat (20 * clks_per_bit) @(posedge clock);
    @(negedge clock);
    check_level(0);
    checks++;
    assert (exp_q.size() == 0) else begin
      $display("Dump ended with %0d characters still expected", exp_q.size());
      count_error();
    end
    end_test("6 no capture during a dump");

    $display("Tests done, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
source/telemetry_pkg.sv
source/state_capture.sv
source/telemetry_fifo.sv
source/hex_dump.sv
source/uart_tx.sv
source/uart_rx.sv
source/telemetry_top.sv
verification/telemetry_asserts.sv
verification/telemetry_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = telemetry_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
